// ==== src/game_pkg.sv ====
package game_pkg;

	// Bus and memory widths
	typedef logic [31:0] word_t;
	typedef logic [12:0] addr_t;       // Word address, bit 12 picks the window
	typedef logic [11:0] dmem_addr_t;
	typedef logic [4:0]  reg_idx_t;    // Address bits 6:2

	// Box fields carry X or width high, Y or height low
	typedef logic [31:0] box_t;
	typedef logic [15:0] coord_t;
	typedef logic [3:0]  coll_t;       // {inside, both, y, x}
	typedef logic [15:0] count_t;      // Damage and lives

	typedef enum logic [1:0] {
		HIT_IDLE,
		HIT_STRIKE,
		HIT_COOLDOWN
	} hit_state_t;

	// Register window map
	localparam reg_idx_t REG_POS_P1     = 5'd0;
	localparam reg_idx_t REG_POS_P2     = 5'd1;
	localparam reg_idx_t REG_SIZE_P1    = 5'd2;
	localparam reg_idx_t REG_SIZE_P2    = 5'd3;
	localparam reg_idx_t REG_STAGE_POS  = 5'd4;
	localparam reg_idx_t REG_STAGE_SIZE = 5'd5;
	localparam reg_idx_t REG_COLL_P1    = 5'd8;   // Read only from here to REG_REACH
	localparam reg_idx_t REG_COLL_P2    = 5'd9;
	localparam reg_idx_t REG_REACH      = 5'd10;
	localparam reg_idx_t REG_DAMAGE_P1  = 5'd12;
	localparam reg_idx_t REG_DAMAGE_P2  = 5'd13;
	localparam reg_idx_t REG_LIVES_P1   = 5'd14;
	localparam reg_idx_t REG_LIVES_P2   = 5'd15;
	localparam reg_idx_t REG_FRAME      = 5'd16;  // Read only

	// Starting layout of the arena
	localparam box_t RESET_POS_P1     = 32'h016000fa;
	localparam box_t RESET_POS_P2     = 32'h02a900fa;
	localparam box_t RESET_SIZE_P1    = 32'h0085007d;
	localparam box_t RESET_SIZE_P2    = 32'h00590055;
	localparam box_t RESET_STAGE_POS  = 32'h01580014;
	localparam box_t RESET_STAGE_SIZE = 32'h01CC006E;

	// Game rules
	localparam count_t START_LIVES = 16'd3;
	localparam count_t HIT_DAMAGE  = 16'd10;
	localparam count_t KO_DAMAGE   = 16'd100;

	localparam int FRAME_DIV       = 16;  // Cycles per frame, short for simulation
	localparam int COOLDOWN_FRAMES = 4;
	localparam int DIV_W           = $clog2(FRAME_DIV);
	localparam int COOL_W          = $clog2(COOLDOWN_FRAMES + 1);

	typedef logic [DIV_W-1:0]  div_t;
	typedef logic [COOL_W-1:0] cool_t;

endpackage

// ==== src/data_mem.sv ====
`timescale 1ns/1ps

module data_mem (
	input  logic                   clock,
	input  game_pkg::dmem_addr_t   index,
	input  game_pkg::word_t        wdata,
	input  logic                   we,
	output game_pkg::word_t        q
);

	localparam int DEPTH = 1 << $bits(game_pkg::dmem_addr_t);

	game_pkg::word_t mem [0:DEPTH-1];

	// Single port, write first in the array, read returns the old word
	always_ff @(posedge clock) begin
		if (we) begin
			mem[index] <= wdata;
		end
		q <= mem[index];
	end

endmodule

// ==== src/collision_unit.sv ====
`timescale 1ns/1ps

module collision_unit (
	input  game_pkg::box_t  box_pos,
	input  game_pkg::box_t  box_size,
	input  game_pkg::box_t  ref_pos,
	input  game_pkg::box_t  ref_size,
	output game_pkg::coll_t coll
);

	game_pkg::coord_t bx, by, bw, bh;
	game_pkg::coord_t rx, ry, rw, rh;
	logic [16:0] b_right, b_bottom;  // One spare bit so edges never wrap
	logic [16:0] r_right, r_bottom;
	logic ovl_x, ovl_y, in_x, in_y;

	assign {bx, by} = box_pos;
	assign {bw, bh} = box_size;
	assign {rx, ry} = ref_pos;
	assign {rw, rh} = ref_size;

	assign b_right  = {1'b0, bx} + {1'b0, bw};
	assign b_bottom = {1'b0, by} + {1'b0, bh};
	assign r_right  = {1'b0, rx} + {1'b0, rw};
	assign r_bottom = {1'b0, ry} + {1'b0, rh};

	// Each start below the other's far edge
	assign ovl_x = ({1'b0, bx} < r_right) && ({1'b0, rx} < b_right);
	assign ovl_y = ({1'b0, by} < r_bottom) && ({1'b0, ry} < b_bottom);

	assign in_x = (bx >= rx) && (b_right <= r_right);
	assign in_y = (by >= ry) && (b_bottom <= r_bottom);

	assign coll = {in_x && in_y, ovl_x && ovl_y, ovl_y, ovl_x};

endmodule

// ==== src/frame_timer.sv ====
`timescale 1ns/1ps

module frame_timer (
	input  logic            clock,
	input  logic            rst_n,
	output logic            frame_tick,
	output game_pkg::word_t frame_count
);

	game_pkg::div_t div_cnt;

	// Last cycle of each frame
	assign frame_tick = (div_cnt == game_pkg::div_t'(game_pkg::FRAME_DIV - 1));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			div_cnt     <= '0;
			frame_count <= '0;
		end else if (frame_tick) begin
			div_cnt     <= '0;
			frame_count <= frame_count + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

// ==== src/hit_fsm.sv ====
`timescale 1ns/1ps

module hit_fsm (
	input  logic clock,
	input  logic rst_n,
	input  logic attack,      // Button level
	input  logic reach,       // Opponent overlaps the attacker
	input  logic frame_tick,
	output logic hit
);

	game_pkg::hit_state_t state;
	game_pkg::cool_t      frames;
	logic                 attack_q;
	logic                 press;

	assign press = attack && !attack_q;
	assign hit   = (state == game_pkg::HIT_STRIKE);  // One cycle per landed attack

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= game_pkg::HIT_IDLE;
			frames   <= '0;
			attack_q <= 1'b0;
		end else begin
			attack_q <= attack;
			case (state)
				game_pkg::HIT_IDLE: begin
					if (press) begin
						// A whiff still costs the cooldown
						state <= reach ? game_pkg::HIT_STRIKE : game_pkg::HIT_COOLDOWN;
					end
				end
				game_pkg::HIT_STRIKE: begin
					state <= game_pkg::HIT_COOLDOWN;
				end
				game_pkg::HIT_COOLDOWN: begin
					// First tick only lines up with the frame grid, then whole frames count
					if (frame_tick) begin
						if (frames == game_pkg::cool_t'(game_pkg::COOLDOWN_FRAMES)) begin
							frames <= '0;
							state  <= game_pkg::HIT_IDLE;
						end else begin
							frames <= frames + 1'b1;
						end
					end
				end
				default: state <= game_pkg::HIT_IDLE;
			endcase
		end
	end

endmodule

// ==== src/damage_accum.sv ====
`timescale 1ns/1ps

module damage_accum (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             hit_in,       // Opponent landed a hit
	input  logic             load_damage,
	input  logic             load_lives,
	input  game_pkg::count_t load_value,
	output game_pkg::count_t damage,
	output game_pkg::count_t lives
);

	logic [$bits(game_pkg::count_t):0] sum;  // Extra bit keeps a huge load from wrapping
	logic                              knockout;

	assign sum      = {1'b0, damage} + {1'b0, game_pkg::HIT_DAMAGE};
	assign knockout = (sum >= {1'b0, game_pkg::KO_DAMAGE});

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			damage <= '0;
			lives  <= game_pkg::START_LIVES;
		end else if (load_damage || load_lives) begin
			// Processor restart of a round beats a hit in the same cycle
			if (load_damage) begin
				damage <= load_value;
			end
			if (load_lives) begin
				lives <= load_value;
			end
		end else if (hit_in) begin
			if (knockout) begin
				damage <= '0;
				if (lives != '0) begin
					lives <= lives - 1'b1;  // Floor at zero
				end
			end else begin
				damage <= game_pkg::count_t'(sum);
			end
		end
	end

endmodule

// ==== src/mmio.sv ====
`timescale 1ns/1ps

module mmio (
	input  logic            clock,
	input  logic            rst_n,
	input  game_pkg::addr_t address,
	input  game_pkg::word_t data_in,
	input  logic            wren,
	output game_pkg::word_t data_out,
	input  logic            attack_p1,
	input  logic            attack_p2,
	output logic            hit_p1,
	output logic            hit_p2
);

	game_pkg::reg_idx_t idx;
	logic               win_we;
	logic               sel_win_q;   // Previous access went to the window
	game_pkg::word_t    mem_q, win_rdata, win_q;

	game_pkg::box_t  pos_p1, pos_p2, size_p1, size_p2, stage_pos, stage_size;
	game_pkg::coll_t coll_p1, coll_p2, reach;

	logic             frame_tick;
	game_pkg::word_t  frame_count;
	game_pkg::count_t damage_p1, damage_p2, lives_p1, lives_p2, load_value;
	logic             load_dmg_p1, load_dmg_p2, load_lives_p1, load_lives_p2;

	assign idx        = address[6:2];
	assign win_we     = wren && address[12];
	assign load_value = data_in[15:0];

	assign load_dmg_p1   = win_we && (idx == game_pkg::REG_DAMAGE_P1);
	assign load_dmg_p2   = win_we && (idx == game_pkg::REG_DAMAGE_P2);
	assign load_lives_p1 = win_we && (idx == game_pkg::REG_LIVES_P1);
	assign load_lives_p2 = win_we && (idx == game_pkg::REG_LIVES_P2);

	data_mem u_dmem (
		.clock (clock),
		.index (address[11:0]),
		.wdata (data_in),
		.we    (wren && !address[12]),
		.q     (mem_q)
	);

	// Writable boxes, the rest of the window lives in the sub-blocks
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pos_p1     <= game_pkg::RESET_POS_P1;
			pos_p2     <= game_pkg::RESET_POS_P2;
			size_p1    <= game_pkg::RESET_SIZE_P1;
			size_p2    <= game_pkg::RESET_SIZE_P2;
			stage_pos  <= game_pkg::RESET_STAGE_POS;
			stage_size <= game_pkg::RESET_STAGE_SIZE;
		end else if (win_we) begin
			case (idx)
				game_pkg::REG_POS_P1:     pos_p1 <= data_in;
				game_pkg::REG_POS_P2:     pos_p2 <= data_in;
				game_pkg::REG_SIZE_P1:    size_p1 <= data_in;
				game_pkg::REG_SIZE_P2:    size_p2 <= data_in;
				game_pkg::REG_STAGE_POS:  stage_pos <= data_in;
				game_pkg::REG_STAGE_SIZE: stage_size <= data_in;
				default: ;  // Read-only or unmapped
			endcase
		end
	end

	collision_unit u_coll_p1 (
		.box_pos  (pos_p1),
		.box_size (size_p1),
		.ref_pos  (stage_pos),
		.ref_size (stage_size),
		.coll     (coll_p1)
	);

	collision_unit u_coll_p2 (
		.box_pos  (pos_p2),
		.box_size (size_p2),
		.ref_pos  (stage_pos),
		.ref_size (stage_size),
		.coll     (coll_p2)
	);

	// Attack reach, player 1 tested against player 2
	collision_unit u_reach (
		.box_pos  (pos_p1),
		.box_size (size_p1),
		.ref_pos  (pos_p2),
		.ref_size (size_p2),
		.coll     (reach)
	);

	frame_timer u_timer (
		.clock       (clock),
		.rst_n       (rst_n),
		.frame_tick  (frame_tick),
		.frame_count (frame_count)
	);

	hit_fsm u_hit_p1 (
		.clock      (clock),
		.rst_n      (rst_n),
		.attack     (attack_p1),
		.reach      (reach[2]),
		.frame_tick (frame_tick),
		.hit        (hit_p1)
	);

	hit_fsm u_hit_p2 (
		.clock      (clock),
		.rst_n      (rst_n),
		.attack     (attack_p2),
		.reach      (reach[2]),
		.frame_tick (frame_tick),
		.hit        (hit_p2)
	);

	// Each player takes the opponent's hits
	damage_accum u_dmg_p1 (
		.clock       (clock),
		.rst_n       (rst_n),
		.hit_in      (hit_p2),
		.load_damage (load_dmg_p1),
		.load_lives  (load_lives_p1),
		.load_value  (load_value),
		.damage      (damage_p1),
		.lives       (lives_p1)
	);

	damage_accum u_dmg_p2 (
		.clock       (clock),
		.rst_n       (rst_n),
		.hit_in      (hit_p1),
		.load_damage (load_dmg_p2),
		.load_lives  (load_lives_p2),
		.load_value  (load_value),
		.damage      (damage_p2),
		.lives       (lives_p2)
	);

	always_comb begin
		case (idx)
			game_pkg::REG_POS_P1:     win_rdata = pos_p1;
			game_pkg::REG_POS_P2:     win_rdata = pos_p2;
			game_pkg::REG_SIZE_P1:    win_rdata = size_p1;
			game_pkg::REG_SIZE_P2:    win_rdata = size_p2;
			game_pkg::REG_STAGE_POS:  win_rdata = stage_pos;
			game_pkg::REG_STAGE_SIZE: win_rdata = stage_size;
			game_pkg::REG_COLL_P1:    win_rdata = game_pkg::word_t'(coll_p1);
			game_pkg::REG_COLL_P2:    win_rdata = game_pkg::word_t'(coll_p2);
			game_pkg::REG_REACH:      win_rdata = game_pkg::word_t'(reach);
			game_pkg::REG_DAMAGE_P1:  win_rdata = game_pkg::word_t'(damage_p1);
			game_pkg::REG_DAMAGE_P2:  win_rdata = game_pkg::word_t'(damage_p2);
			game_pkg::REG_LIVES_P1:   win_rdata = game_pkg::word_t'(lives_p1);
			game_pkg::REG_LIVES_P2:   win_rdata = game_pkg::word_t'(lives_p2);
			game_pkg::REG_FRAME:      win_rdata = frame_count;
			default:                  win_rdata = '0;
		endcase
	end

	// Read-back register, aligned with the RAM's registered output
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			win_q     <= '0;
			sel_win_q <= 1'b1;  // Shows the cleared window word until the first read
		end else begin
			win_q     <= win_rdata;
			sel_win_q <= address[12];
		end
	end

	assign data_out = sel_win_q ? win_q : mem_q;

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clock,
	output logic rst_n
);

	localparam int RESET_CYCLES = 3;

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;  // 20 ns period
	end

	// Reset leaves on a falling edge, where the stimulus also changes
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

// ==== bench/mmio_asserts.sv ====
`timescale 1ns/1ps

module mmio_asserts (
	input logic            clock,
	input logic            rst_n,
	input logic            hit_p1,
	input logic            hit_p2,
	input game_pkg::coll_t reach
);

	localparam int MIN_GAP = game_pkg::COOLDOWN_FRAMES * game_pkg::FRAME_DIV;

	int unsigned failures = 0;
	logic [7:0]  gap_p1, gap_p2;  // Cycles since the last strobe, saturating

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			gap_p1 <= '1;
			gap_p2 <= '1;
		end else begin
			gap_p1 <= hit_p1 ? 8'd1 : ((gap_p1 == '1) ? gap_p1 : gap_p1 + 8'd1);
			gap_p2 <= hit_p2 ? 8'd1 : ((gap_p2 == '1) ? gap_p2 : gap_p2 + 8'd1);
		end
	end

	single_p1: assert property (@(posedge clock) disable iff (!rst_n) hit_p1 |=> !hit_p1)
		else begin failures++; $error("hit_p1 held for more than one cycle"); end
	single_p2: assert property (@(posedge clock) disable iff (!rst_n) hit_p2 |=> !hit_p2)
		else begin failures++; $error("hit_p2 held for more than one cycle"); end

	// Strobe follows the edge where reach was sampled
	reach_p1: assert property (@(posedge clock) disable iff (!rst_n) hit_p1 |-> $past(reach[2]))
		else begin failures++; $error("hit_p1 without reach"); end
	reach_p2: assert property (@(posedge clock) disable iff (!rst_n) hit_p2 |-> $past(reach[2]))
		else begin failures++; $error("hit_p2 without reach"); end

	quiet_rst: assert property (@(posedge clock) !rst_n |=> !hit_p1 && !hit_p2)
		else begin failures++; $error("hit strobe during reset"); end

	gap_hit_p1: assert property (@(posedge clock) disable iff (!rst_n) hit_p1 |-> gap_p1 >= MIN_GAP)
		else begin failures++; $error("hit_p1 repeated inside cooldown"); end
	gap_hit_p2: assert property (@(posedge clock) disable iff (!rst_n) hit_p2 |-> gap_p2 >= MIN_GAP)
		else begin failures++; $error("hit_p2 repeated inside cooldown"); end

endmodule

// ==== bench/tb_mmio.sv ====
`timescale 1ns/1ps

module tb_mmio;

	typedef enum logic [2:0] {
		OP_WRITE, OP_READ, OP_PRESS, OP_RELEASE, OP_WAIT, OP_SAMPLE, OP_DELTA
	} op_t;

	// Press and release carry the player number in addr
	typedef struct packed {
		op_t             op;
		game_pkg::addr_t addr;
		game_pkg::word_t data;
		game_pkg::word_t exp;
	} entry_t;

	logic            clock, rst_n, wren, attack_p1, attack_p2, hit_p1, hit_p2;
	game_pkg::addr_t address;
	game_pkg::word_t data_in, data_out;

	entry_t          tbl[$];
	logic [31:0]     lcg_state = 32'hbfc1;
	game_pkg::word_t mark;  // Frame count from the last sample
	int unsigned     checks = 0;
	int unsigned     errors = 0;
	int unsigned     cycles = 0;
	int unsigned     limit = 0;

	tb_clock u_clk (.clock(clock), .rst_n(rst_n));

	mmio u_dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.address   (address),
		.data_in   (data_in),
		.wren      (wren),
		.data_out  (data_out),
		.attack_p1 (attack_p1),
		.attack_p2 (attack_p2),
		.hit_p1    (hit_p1),
		.hit_p2    (hit_p2)
	);

	bind mmio mmio_asserts u_asserts (
		.clock  (clock),
		.rst_n  (rst_n),
		.hit_p1 (hit_p1),
		.hit_p2 (hit_p2),
		.reach  (reach)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic game_pkg::addr_t win_addr(input game_pkg::reg_idx_t idx);
		return {1'b1, 5'b0, idx, 2'b00};
	endfunction

	task automatic add_entry(input op_t op, input game_pkg::addr_t a,
			input game_pkg::word_t d, input game_pkg::word_t e);
		tbl.push_back('{op, a, d, e});
	endtask

	task automatic build_table();
		game_pkg::dmem_addr_t mem_addrs [4];
		game_pkg::word_t      words [4];
		int                   k;
		mem_addrs = '{12'h005, 12'h0a3, 12'hfff, 12'h07c};
		// Reset layout, collisions of that layout, damage and lives
		add_entry(OP_READ, win_addr(game_pkg::REG_POS_P1), 0, 32'h016000fa);
		add_entry(OP_READ, win_addr(game_pkg::REG_POS_P2), 0, 32'h02a900fa);
		add_entry(OP_READ, win_addr(game_pkg::REG_SIZE_P1), 0, 32'h0085007d);
		add_entry(OP_READ, win_addr(game_pkg::REG_SIZE_P2), 0, 32'h00590055);
		add_entry(OP_READ, win_addr(game_pkg::REG_STAGE_POS), 0, 32'h01580014);
		add_entry(OP_READ, win_addr(game_pkg::REG_STAGE_SIZE), 0, 32'h01cc006e);
		add_entry(OP_READ, win_addr(game_pkg::REG_COLL_P1), 0, 32'h1);
		add_entry(OP_READ, win_addr(game_pkg::REG_COLL_P2), 0, 32'h1);
		add_entry(OP_READ, win_addr(game_pkg::REG_REACH), 0, 32'h2);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P1), 0, 32'h0);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P2), 0, 32'h0);
		add_entry(OP_READ, win_addr(game_pkg::REG_LIVES_P1), 0, 32'h3);
		add_entry(OP_READ, win_addr(game_pkg::REG_LIVES_P2), 0, 32'h3);
		for (k = 0; k < 4; k++) begin
			words[k] = lcg_next();
			add_entry(OP_WRITE, {1'b0, mem_addrs[k]}, words[k], 0);
		end
		add_entry(OP_WRITE, 13'h107c, 32'h5a5a0f0f, 0);  // Unmapped window word over 0x07c
		for (k = 0; k < 4; k++) begin
			add_entry(OP_READ, {1'b0, mem_addrs[k]}, 0, words[k]);
		end
		add_entry(OP_READ, 13'h107c, 0, 0);
		// P1 inside the stage, P2 off it, then partly on it
		add_entry(OP_WRITE, win_addr(game_pkg::REG_POS_P1), 32'h01900032, 0);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_SIZE_P1), 32'h00640028, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_COLL_P1), 0, 32'hf);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_POS_P2), 32'h038400c8, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_COLL_P2), 0, 32'h0);
		add_entry(OP_READ, win_addr(game_pkg::REG_REACH), 0, 32'h0);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_POS_P2), 32'h02bc0064, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_COLL_P2), 0, 32'h7);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_POS_P2), 32'h0258003c, 0);  // Apart
		add_entry(OP_READ, win_addr(game_pkg::REG_REACH), 0, 32'h2);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_POS_P2), 32'h01c2003c, 0);  // Together
		add_entry(OP_READ, win_addr(game_pkg::REG_REACH), 0, 32'h7);
		// Hit, ignored press in cooldown, hit again after the wait
		add_entry(OP_PRESS, 1, 0, 1);
		add_entry(OP_RELEASE, 1, 0, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P2), 0, 32'd10);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P1), 0, 32'd0);
		add_entry(OP_PRESS, 1, 0, 0);
		add_entry(OP_RELEASE, 1, 0, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P2), 0, 32'd10);
		add_entry(OP_WAIT, 0, 6, 0);
		add_entry(OP_PRESS, 1, 0, 1);
		add_entry(OP_RELEASE, 1, 0, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P2), 0, 32'd20);
		add_entry(OP_WAIT, 0, 6, 0);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_POS_P2), 32'h0258003c, 0);
		add_entry(OP_PRESS, 2, 0, 0);  // Out of reach
		add_entry(OP_RELEASE, 2, 0, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P1), 0, 32'd0);
		// Knockout from 95, then knockout with no lives left
		add_entry(OP_WRITE, win_addr(game_pkg::REG_POS_P2), 32'h01c2003c, 0);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_DAMAGE_P2), 32'd95, 0);
		add_entry(OP_PRESS, 1, 0, 1);
		add_entry(OP_RELEASE, 1, 0, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P2), 0, 32'd0);
		add_entry(OP_READ, win_addr(game_pkg::REG_LIVES_P2), 0, 32'd2);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_LIVES_P1), 32'd0, 0);
		add_entry(OP_WRITE, win_addr(game_pkg::REG_DAMAGE_P1), 32'd95, 0);
		add_entry(OP_WAIT, 0, 6, 0);
		add_entry(OP_PRESS, 2, 0, 1);
		add_entry(OP_RELEASE, 2, 0, 0);
		add_entry(OP_READ, win_addr(game_pkg::REG_DAMAGE_P1), 0, 32'd0);
		add_entry(OP_READ, win_addr(game_pkg::REG_LIVES_P1), 0, 32'd0);
		add_entry(OP_SAMPLE, win_addr(game_pkg::REG_FRAME), 0, 0);
		add_entry(OP_WAIT, 0, 3, 0);
		add_entry(OP_DELTA, win_addr(game_pkg::REG_FRAME), 0, 32'd3);
	endtask

	// One rising edge, back on the falling edge where outputs are stable
	task automatic next_cycle();
		@(posedge clock);
		@(negedge clock);
	endtask

	task automatic run_entry(input int n);
		entry_t          e;
		game_pkg::word_t got;
		string           name;
		e = tbl[n];
		case (e.op)
			OP_WRITE: begin
				address = e.addr;
				data_in = e.data;
				wren    = 1'b1;
				next_cycle();
				wren    = 1'b0;
			end
			OP_PRESS, OP_RELEASE: begin
				if (e.addr == 1) attack_p1 = (e.op == OP_PRESS);
				else attack_p2 = (e.op == OP_PRESS);
				next_cycle();
			end
			OP_WAIT: begin
				// One cycle short, so the ops around it sit whole frames apart
				repeat (e.data * game_pkg::FRAME_DIV - 1) @(posedge clock);
				@(negedge clock);
			end
			default: begin
				address = e.addr;
				next_cycle();
			end
		endcase
		if (e.op inside {OP_READ, OP_PRESS, OP_DELTA}) begin
			got  = (e.op == OP_DELTA) ? data_out - mark : data_out;
			name = (e.op == OP_DELTA) ? "frame delta" : "data_out";
			if (e.op == OP_PRESS) begin
				got  = {31'b0, (e.addr == 1) ? hit_p1 : hit_p2};
				name = (e.addr == 1) ? "hit_p1" : "hit_p2";
			end
			checks++;
			if (got !== e.exp) begin
				errors++;
				$display("Mismatch %s at entry %0d, addr %h: got %h, expected %h",
					name, n, e.addr, got, e.exp);
			end else begin
				$display("entry %0d: %s at %h = %h ok", n, name, e.addr, got);
			end
		end
		if (e.op == OP_SAMPLE) mark = data_out;
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("Timeout: no finish after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		address   = '0;
		data_in   = '0;
		wren      = 1'b0;
		attack_p1 = 1'b0;
		attack_p2 = 1'b0;
		mark      = '0;
		build_table();
		limit = tbl.size() * (game_pkg::COOLDOWN_FRAMES * game_pkg::FRAME_DIV + 8);
		@(posedge rst_n);
		foreach (tbl[i]) run_entry(i);
		errors += u_dut.u_asserts.failures;
		$display("%0d checks, %0d errors, %0d assertion failures",
			checks, errors, u_dut.u_asserts.failures);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
src/game_pkg.sv
src/data_mem.sv
src/collision_unit.sv
src/frame_timer.sv
src/hit_fsm.sv
src/damage_accum.sv
src/mmio.sv
bench/tb_clock.sv
bench/mmio_asserts.sv
bench/tb_mmio.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run with Verilator, then judge the run by its log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmio -f compile.f -o sim_mmio \
	|| { echo "Build failed"; exit 1; }
./obj_dir/sim_mmio +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } \
	|| grep -q "TEST OK" sim.log || { echo "No result line in sim.log"; exit 1; }
